/* src.f */
src/cpuPkg.sv
src/fetchStage.sv
src/decodeUnit.sv
src/regFile.sv
src/hazardUnit.sv
src/executeStage.sv
src/cpuCore.sv
verif/clockGen.sv
verif/cpuCoreTb.sv

/* verif/cpuCoreTb.sv */
module cpuCoreTb;

    logic            clk;
    logic            reset;
    logic            resetReq;
    logic [31:0]     pc;
    logic [31:0]     instr;
    logic [31:0]     memRdata;
    cpuPkg::memReq_t memReq;
    cpuPkg::wbInfo_t wbInfo;

    logic [31:0] imem [0:15];
    logic [31:0] dmem [0:63];

    // test table
    int          testCount;
    string       testName   [0:7];
    logic [31:0] progWord   [0:7][0:11];
    int          progLen    [0:7];
    logic [4:0]  expNum     [0:7][0:11];
    logic [31:0] expData    [0:7][0:11];
    logic [31:0] expPc      [0:7][0:11];
    int          expLen     [0:7];
    int          storeCount [0:7];
    logic [31:0] storeAddr  [0:7];
    logic [31:0] storeData  [0:7];

    logic [4:0]  gotNum [$];
    logic [31:0] gotData [$];
    logic [31:0] gotPc [$];
    logic [31:0] gotStoreAddr [$];
    logic [31:0] gotStoreData [$];
    int          passCount;
    int          failCount;
    int          watchLimit;

    clockGen u_clockGen (
        .resetReq(resetReq),
        .clk     (clk),
        .reset   (reset)
    );

    cpuCore u_cpuCore (
        .clk     (clk),
        .reset   (reset),
        .pc      (pc),
        .instr   (instr),
        .memReq  (memReq),
        .memRdata(memRdata),
        .wbInfo  (wbInfo)
    );

    assign instr    = imem[pc[5:2]];
    assign memRdata = memReq.en ? dmem[memReq.addr[7:2]] : 'x;   // same-cycle, only when strobed

    always @(posedge clk) begin
        if (memReq.en === 1'b1 && memReq.wen === 1'b1) begin
            dmem[memReq.addr[7:2]] = memReq.wdata;
        end
    end

    function automatic logic [31:0] rInstr(input logic [5:0] funct, input int rd, input int rs,
                                           input int rt, input int shamt);
        return {6'h00, 5'(rs), 5'(rt), 5'(rd), 5'(shamt), funct};
    endfunction

    function automatic logic [31:0] iInstr(input logic [5:0] op, input int rt, input int rs,
                                           input logic [15:0] imm);
        return {op, 5'(rs), 5'(rt), imm};
    endfunction

    function automatic logic [31:0] jInstr(input int index);
        return {6'h02, 26'(index)};
    endfunction

    // address-dependent contents of untouched data words
    function automatic logic [31:0] dataFill(input logic [31:0] addr);
        return 32'hc3a5_96f0 ^ (addr * 32'h0001_0003);
    endfunction

    task automatic addInstr(input int t, input logic [31:0] word);
        progWord[t][progLen[t]] = word;
        progLen[t]++;
    endtask

    task automatic addInstrWb(input int t, input logic [31:0] word, input int num,
                              input logic [31:0] data);
        expPc[t][expLen[t]]   = 32'(progLen[t] * 4);   // byte address of this word
        addInstr(t, word);
        expNum[t][expLen[t]]  = 5'(num);
        expData[t][expLen[t]] = data;
        expLen[t]++;
    endtask

    task automatic buildTable();
        logic [15:0] immA;
        logic [15:0] immB;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [31:0] s;
        int          t;

        testCount = 5;
        for (t = 0; t < 8; t++) begin
            progLen[t]    = 0;
            expLen[t]     = 0;
            storeCount[t] = 0;
        end
        immA = 16'($urandom);
        immB = 16'($urandom);
        a    = {{16{immA[15]}}, immA};   // addiu sign-extends
        b    = {{16{immB[15]}}, immB};

        t = 0;
        testName[t] = "aluOps";
        addInstrWb(t, iInstr(cpuPkg::opAddiu, 1, 0, immA), 1, a);
        addInstrWb(t, iInstr(cpuPkg::opAddiu, 2, 0, immB), 2, b);
        addInstrWb(t, rInstr(cpuPkg::fnAddu, 3, 1, 2, 0), 3, a + b);
        addInstrWb(t, rInstr(cpuPkg::fnSubu, 4, 1, 2, 0), 4, a - b);
        addInstrWb(t, rInstr(cpuPkg::fnAnd, 5, 1, 2, 0), 5, a & b);
        addInstrWb(t, rInstr(cpuPkg::fnOr, 6, 1, 2, 0), 6, a | b);
        addInstrWb(t, rInstr(cpuPkg::fnXor, 7, 1, 2, 0), 7, a ^ b);
        addInstrWb(t, rInstr(cpuPkg::fnSlt, 8, 1, 2, 0), 8,
                   ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
        addInstrWb(t, rInstr(cpuPkg::fnSlt, 9, 2, 1, 0), 9,
                   ($signed(b) < $signed(a)) ? 32'd1 : 32'd0);
        addInstr(t, jInstr(9));

        t = 1;
        testName[t] = "shiftsLui";
        c = {16'h1234, 16'h0000};
        addInstrWb(t, iInstr(cpuPkg::opLui, 1, 0, 16'h1234), 1, c);
        c = c | 32'h0000_abcd;
        addInstrWb(t, iInstr(cpuPkg::opOri, 1, 1, 16'habcd), 1, c);
        addInstrWb(t, rInstr(cpuPkg::fnSll, 2, 0, 1, 4), 2, c << 4);
        addInstrWb(t, rInstr(cpuPkg::fnSrl, 3, 0, 1, 8), 3, c >> 8);
        addInstrWb(t, iInstr(cpuPkg::opAddiu, 0, 0, 16'h0055), 0, 32'h0000_0055);
        addInstrWb(t, rInstr(cpuPkg::fnAddu, 4, 0, 1, 0), 4, c);   // r0 reads back as zero
        addInstrWb(t, iInstr(cpuPkg::opLui, 5, 0, 16'hf000), 5, 32'hf000_0000);
        addInstrWb(t, rInstr(cpuPkg::fnSrl, 6, 0, 5, 4), 6, 32'hf000_0000 >> 4);
        addInstrWb(t, iInstr(cpuPkg::opAndi, 7, 1, 16'hff0f), 7, c & 32'h0000_ff0f);
        addInstr(t, jInstr(9));

        t = 2;
        testName[t] = "forwardChain";
        a = 32'd5;
        b = 32'hffff_fff9;
        addInstrWb(t, iInstr(cpuPkg::opAddiu, 1, 0, 16'h0005), 1, a);
        addInstrWb(t, iInstr(cpuPkg::opAddiu, 2, 0, 16'hfff9), 2, b);
        s = a + b;
        addInstrWb(t, rInstr(cpuPkg::fnAddu, 3, 1, 2, 0), 3, s);
        s = s + a;
        addInstrWb(t, rInstr(cpuPkg::fnAddu, 3, 3, 1, 0), 3, s);
        s = s + b;
        addInstrWb(t, rInstr(cpuPkg::fnAddu, 3, 3, 2, 0), 3, s);
        addInstrWb(t, rInstr(cpuPkg::fnAddu, 4, 3, 3, 0), 4, s + s);
        addInstrWb(t, rInstr(cpuPkg::fnAddu, 5, 4, 3, 0), 5, s + s + s);
        addInstr(t, jInstr(7));

        t = 3;
        testName[t] = "loadStore";
        addInstrWb(t, iInstr(cpuPkg::opAddiu, 1, 0, 16'h0040), 1, 32'h40);
        addInstrWb(t, iInstr(cpuPkg::opAddiu, 2, 0, 16'h1357), 2, 32'h1357);
        addInstr(t, iInstr(cpuPkg::opSw, 2, 1, 16'h0008));
        addInstrWb(t, iInstr(cpuPkg::opLw, 3, 1, 16'h0008), 3, 32'h1357);
        addInstrWb(t, rInstr(cpuPkg::fnAddu, 4, 3, 2, 0), 4, 32'h1357 + 32'h1357);
        addInstrWb(t, iInstr(cpuPkg::opLw, 5, 1, 16'h0010), 5, dataFill(32'h50));
        addInstrWb(t, rInstr(cpuPkg::fnAddu, 6, 5, 1, 0), 6, dataFill(32'h50) + 32'h40);
        addInstr(t, jInstr(7));
        storeCount[t] = 1;
        storeAddr[t]  = 32'h48;
        storeData[t]  = 32'h1357;

        t = 4;
        testName[t] = "controlFlow";
        addInstrWb(t, iInstr(cpuPkg::opAddiu, 1, 0, 16'h0003), 1, 32'd3);
        addInstrWb(t, iInstr(cpuPkg::opAddiu, 2, 0, 16'h0003), 2, 32'd3);
        addInstr(t, iInstr(cpuPkg::opBeq, 2, 1, 16'h0002));   // taken, to word 5
        addInstr(t, iInstr(cpuPkg::opAddiu, 3, 0, 16'h0011));
        addInstr(t, iInstr(cpuPkg::opAddiu, 4, 0, 16'h0022));
        addInstr(t, iInstr(cpuPkg::opBne, 2, 1, 16'h0003));   // falls through
        addInstrWb(t, iInstr(cpuPkg::opAddiu, 5, 0, 16'h0033), 5, 32'h33);
        addInstr(t, jInstr(9));
        addInstr(t, iInstr(cpuPkg::opAddiu, 6, 0, 16'h0044));
        addInstrWb(t, iInstr(cpuPkg::opAddiu, 7, 0, 16'h0055), 7, 32'h55);
        addInstr(t, jInstr(10));

        watchLimit = 0;
        for (t = 0; t < testCount; t++) begin
            watchLimit += progLen[t] * 6 + 20;
        end
    endtask

    task automatic loadMemories(input int t);
        int i;

        for (i = 0; i < 16; i++) begin
            if (i < progLen[t]) begin
                imem[i] = progWord[t][i];
            end else begin
                imem[i] = {6'h3f, 26'(i * 4)};   // unknown opcode, acts as nop
            end
        end
        for (i = 0; i < 64; i++) begin
            dmem[i] = dataFill(32'(i * 4));
        end
    endtask

    task automatic runTest(input int t);
        int          i;
        int          errs;
        int          cycles;
        int          jumpSeen;
        logic [31:0] jumpAddr;

        errs     = 0;
        cycles   = 0;
        jumpSeen = 0;
        jumpAddr = 32'((progLen[t] - 1) * 4);
        gotNum.delete();
        gotData.delete();
        gotPc.delete();
        gotStoreAddr.delete();
        gotStoreData.delete();

        @(posedge clk);
        #1 resetReq = 1'b1;
        @(posedge clk);
        #1 resetReq = 1'b0;
        @(posedge clk);   // core is in reset from this edge
        #1 loadMemories(t);
        @(negedge clk);
        while (reset) begin
            if (wbInfo.wen !== 1'b0 || memReq.en !== 1'b0) begin
                $display("test %s: register write or memory strobe active during reset",
                         testName[t]);
                errs++;
            end
            @(negedge clk);
        end
        if (pc !== 32'h0000_0000) begin
            $display("FAILED %s: first fetch address expected 0x%08h, actual 0x%08h",
                     testName[t], 32'h0, pc);
            errs++;
        end
        if (wbInfo.wen !== 1'b0 || memReq.en !== 1'b0) begin
            $display("test %s: register write or memory strobe active right after reset",
                     testName[t]);
            errs++;
        end

        // run until the self-jump has come round enough times to drain the pipe
        while (jumpSeen < 6 && cycles < progLen[t] * 6 + 20) begin
            if (wbInfo.wen === 1'b1) begin
                gotNum.push_back(wbInfo.wnum);
                gotData.push_back(wbInfo.wdata);
                gotPc.push_back(wbInfo.pc);
            end
            if (memReq.en === 1'b1 && memReq.wen === 1'b1) begin
                gotStoreAddr.push_back(memReq.addr);
                gotStoreData.push_back(memReq.wdata);
            end
            if (pc === jumpAddr) begin
                jumpSeen++;
            end
            cycles++;
            @(negedge clk);
        end
        if (jumpSeen < 6) begin
            $display("test %s: program never settled at its final jump", testName[t]);
            errs++;
        end

        for (i = 0; i < expLen[t]; i++) begin
            if (i >= gotNum.size()) begin
                $display("test %s: writeback %0d to r%0d never appeared",
                         testName[t], i, expNum[t][i]);
                errs++;
            end else begin
                if (gotNum[i] !== expNum[t][i] || gotData[i] !== expData[t][i]) begin
                    $display("FAILED %s: writeback %0d expected r%0d=0x%08h, actual r%0d=0x%08h",
                             testName[t], i, expNum[t][i], expData[t][i], gotNum[i], gotData[i]);
                    errs++;
                end
                if (gotPc[i] !== expPc[t][i]) begin
                    $display("FAILED %s: writeback %0d pc expected 0x%08h, actual 0x%08h",
                             testName[t], i, expPc[t][i], gotPc[i]);
                    errs++;
                end
            end
        end
        for (i = expLen[t]; i < gotNum.size(); i++) begin
            $display("test %s: unexpected writeback r%0d = 0x%08h",
                     testName[t], gotNum[i], gotData[i]);
            errs++;
        end

        if (gotStoreAddr.size() != storeCount[t]) begin
            $display("test %s: expected %0d stores but saw %0d",
                     testName[t], storeCount[t], gotStoreAddr.size());
            errs++;
        end else if (storeCount[t] == 1) begin
            if (gotStoreAddr[0] !== storeAddr[t]) begin
                $display("FAILED %s: store address expected 0x%08h, actual 0x%08h",
                         testName[t], storeAddr[t], gotStoreAddr[0]);
                errs++;
            end
            if (gotStoreData[0] !== storeData[t]) begin
                $display("FAILED %s: store data expected 0x%08h, actual 0x%08h",
                         testName[t], storeData[t], gotStoreData[0]);
                errs++;
            end
        end

        if (errs == 0) begin
            passCount++;
            $display("test %-12s ok, %0d writebacks", testName[t], gotNum.size());
        end else begin
            failCount++;
            $display("test %-12s bad, %0d errors", testName[t], errs);
        end
    endtask

    initial begin
        int seedVal;
        int dummy;
        int t;

        resetReq  = 1'b0;
        passCount = 0;
        failCount = 0;
        seedVal   = 38293;
        dummy     = $urandom(seedVal);
        buildTable();
        loadMemories(0);
        for (t = 0; t < testCount; t++) begin
            runTest(t);
        end
        $display("tests run %0d, passed %0d, failed %0d", testCount, passCount, failCount);
        if (failCount == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    initial begin
        #1;
        repeat (watchLimit) @(posedge clk);
        $display("watchdog expired after %0d cycles, run did not complete", watchLimit);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

/* verif/clockGen.sv */
module clockGen (
    input  logic resetReq,
    output logic clk,
    output logic reset
);

    int cyclesLeft;

    initial begin
        clk        = 1'b0;
        reset      = 1'b1;
        cyclesLeft = 4;
        forever begin
            #4 clk = ~clk;   // period 8
        end
    end

    // reset covers four rising edges after power-up or a request
    always @(posedge clk) begin
        if (resetReq) begin
            cyclesLeft = 4;
        end else if (cyclesLeft > 0) begin
            cyclesLeft = cyclesLeft - 1;
        end
        #1 reset = (cyclesLeft != 0);
    end

endmodule

/* src/cpuCore.sv */
module cpuCore (
    input  logic                         clk,
    input  logic                         reset,
    output logic [cpuPkg::dataWidth-1:0] pc,
    input  logic [cpuPkg::dataWidth-1:0] instr,
    output cpuPkg::memReq_t              memReq,
    input  logic [cpuPkg::dataWidth-1:0] memRdata,
    output cpuPkg::wbInfo_t              wbInfo
);

    // hazard and redirect
    logic                         stallFront;
    logic                         flushDecode;
    logic                         flushExecute;
    logic                         branchTaken;
    logic                         isJump;
    logic [cpuPkg::dataWidth-1:0] branchTarget;
    logic [cpuPkg::dataWidth-1:0] jumpTarget;
    logic [cpuPkg::dataWidth-1:0] redirectTarget;
    cpuPkg::fwdSel_t              fwdA;
    cpuPkg::fwdSel_t              fwdB;

    // F/D
    logic [cpuPkg::dataWidth-1:0] fdPc;
    logic [cpuPkg::dataWidth-1:0] fdInstr;

    // decode
    cpuPkg::ctrl_t                decCtrl;
    logic [cpuPkg::dataWidth-1:0] decImm;
    logic [cpuPkg::dataWidth-1:0] rsValue;
    logic [cpuPkg::dataWidth-1:0] rtValue;

    // later stages
    cpuPkg::idEx_t                idExNext;
    cpuPkg::idEx_t                idEx;
    cpuPkg::exMem_t               exMemNext;
    cpuPkg::exMem_t               exMem;
    cpuPkg::memWb_t               memWbNext;
    cpuPkg::memWb_t               memWb;
    logic [cpuPkg::dataWidth-1:0] memResult;

    // flushDecode is high exactly when pc must be redirected
    assign redirectTarget = branchTaken ? branchTarget : jumpTarget;

    fetchStage u_fetchStage (
        .clk           (clk),
        .reset         (reset),
        .stall         (stallFront),
        .redirect      (flushDecode),
        .redirectTarget(redirectTarget),
        .pc            (pc)
    );

    always_ff @(posedge clk) begin
        if (reset || flushDecode) begin
            fdPc    <= '0;
            fdInstr <= '0;   // decodes as a bubble
        end else if (!stallFront) begin
            fdPc    <= pc;
            fdInstr <= instr;
        end
    end

    decodeUnit u_decodeUnit (
        .instr     (fdInstr),
        .pc        (fdPc),
        .ctrl      (decCtrl),
        .imm       (decImm),
        .isJump    (isJump),
        .jumpTarget(jumpTarget)
    );

    regFile u_regFile (
        .clk      (clk),
        .readAddrA(fdInstr[25:21]),
        .readAddrB(fdInstr[20:16]),
        .readDataA(rsValue),
        .readDataB(rtValue),
        .writeEn  (memWb.regWrite),
        .writeAddr(memWb.destReg),
        .writeData(memWb.result)
    );

    hazardUnit u_hazardUnit (
        .decRs       (fdInstr[25:21]),
        .decRt       (fdInstr[20:16]),
        .ex          (idEx),
        .mem         (exMem),
        .wb          (memWb),
        .branchTaken (branchTaken),
        .isJump      (isJump),
        .fwdA        (fwdA),
        .fwdB        (fwdB),
        .stallFront  (stallFront),
        .flushDecode (flushDecode),
        .flushExecute(flushExecute)
    );

    always_comb begin
        idExNext.pc      = fdPc;
        idExNext.ctrl    = decCtrl;
        idExNext.rs      = fdInstr[25:21];
        idExNext.rt      = fdInstr[20:16];
        idExNext.rd      = fdInstr[15:11];
        idExNext.shamt   = fdInstr[10:6];
        idExNext.rsValue = rsValue;
        idExNext.rtValue = rtValue;
        idExNext.imm     = decImm;
    end

    always_ff @(posedge clk) begin
        if (reset || flushExecute) begin
            idEx <= '0;
        end else begin
            idEx <= idExNext;
        end
    end

    executeStage u_executeStage (
        .ex          (idEx),
        .fwdA        (fwdA),
        .fwdB        (fwdB),
        .memResult   (memResult),
        .wbResult    (memWb.result),
        .out         (exMemNext),
        .branchTaken (branchTaken),
        .branchTarget(branchTarget)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            exMem <= '0;
        end else begin
            exMem <= exMemNext;
        end
    end

    // single-cycle strobe, load data comes back this cycle
    always_comb begin
        memReq.en    = exMem.ctrl.memRead || exMem.ctrl.memWrite;
        memReq.wen   = exMem.ctrl.memWrite;
        memReq.addr  = exMem.aluResult;
        memReq.wdata = exMem.storeData;
    end

    assign memResult = exMem.ctrl.memRead ? memRdata : exMem.aluResult;

    always_comb begin
        memWbNext.pc       = exMem.pc;
        memWbNext.regWrite = exMem.ctrl.regWrite;
        memWbNext.destReg  = exMem.destReg;
        memWbNext.result   = memResult;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            memWb <= '0;
        end else begin
            memWb <= memWbNext;
        end
    end

    // r0 writes are reported even though the file drops them
    always_comb begin
        wbInfo.pc    = memWb.pc;
        wbInfo.wen   = memWb.regWrite;
        wbInfo.wnum  = memWb.destReg;
        wbInfo.wdata = memWb.result;
    end

endmodule

/* src/executeStage.sv */
module executeStage (
    input  cpuPkg::idEx_t                ex,
    input  cpuPkg::fwdSel_t              fwdA,
    input  cpuPkg::fwdSel_t              fwdB,
    input  logic [cpuPkg::dataWidth-1:0] memResult,
    input  logic [cpuPkg::dataWidth-1:0] wbResult,
    output cpuPkg::exMem_t               out,
    output logic                         branchTaken,
    output logic [cpuPkg::dataWidth-1:0] branchTarget
);

    logic [cpuPkg::dataWidth-1:0] rsFwd;
    logic [cpuPkg::dataWidth-1:0] rtFwd;
    logic [cpuPkg::dataWidth-1:0] opA;
    logic [cpuPkg::dataWidth-1:0] opB;
    logic [cpuPkg::dataWidth-1:0] aluResult;

    function automatic logic [cpuPkg::dataWidth-1:0] pickOperand(
        input cpuPkg::fwdSel_t              sel,
        input logic [cpuPkg::dataWidth-1:0] regValue,
        input logic [cpuPkg::dataWidth-1:0] memValue,
        input logic [cpuPkg::dataWidth-1:0] wbValue
    );
        case (sel)
            cpuPkg::fromMem: return memValue;
            cpuPkg::fromWb:  return wbValue;
            default:         return regValue;
        endcase
    endfunction

    assign rsFwd = pickOperand(fwdA, ex.rsValue, memResult, wbResult);
    assign rtFwd = pickOperand(fwdB, ex.rtValue, memResult, wbResult);
    assign opA   = rsFwd;
    assign opB   = ex.ctrl.useImm ? ex.imm : rtFwd;

    always_comb begin
        case (ex.ctrl.aluOp)
            cpuPkg::aluAdd: aluResult = opA + opB;   // wraps, no overflow trap
            cpuPkg::aluSub: aluResult = opA - opB;
            cpuPkg::aluAnd: aluResult = opA & opB;
            cpuPkg::aluOr:  aluResult = opA | opB;
            cpuPkg::aluXor: aluResult = opA ^ opB;
            cpuPkg::aluSlt: begin
                aluResult = {{(cpuPkg::dataWidth-1){1'b0}}, $signed(opA) < $signed(opB)};
            end
            cpuPkg::aluSll: aluResult = opB << ex.shamt;   // shifts act on rt
            cpuPkg::aluSrl: aluResult = opB >> ex.shamt;
            cpuPkg::aluLui: aluResult = {opB[15:0], 16'b0};
            default:        aluResult = '0;
        endcase
    end

    always_comb begin
        out.pc        = ex.pc;
        out.ctrl      = ex.ctrl;
        out.destReg   = ex.ctrl.destIsRt ? ex.rt : ex.rd;
        out.aluResult = aluResult;
        out.storeData = rtFwd;
    end

    // compare forwarded values, not the raw decode reads
    always_comb begin
        case (ex.ctrl.branchKind)
            cpuPkg::brEq: branchTaken = (rsFwd == rtFwd);
            cpuPkg::brNe: branchTaken = (rsFwd != rtFwd);
            default:      branchTaken = 1'b0;
        endcase
    end

    assign branchTarget = ex.pc + cpuPkg::wordBytes + {ex.imm[29:0], 2'b00};

endmodule

/* src/hazardUnit.sv */
module hazardUnit (
    input  logic [cpuPkg::regAddrWidth-1:0] decRs,
    input  logic [cpuPkg::regAddrWidth-1:0] decRt,
    input  cpuPkg::idEx_t                   ex,
    input  cpuPkg::exMem_t                  mem,
    input  cpuPkg::memWb_t                  wb,
    input  logic                            branchTaken,
    input  logic                            isJump,
    output cpuPkg::fwdSel_t                 fwdA,
    output cpuPkg::fwdSel_t                 fwdB,
    output logic                            stallFront,
    output logic                            flushDecode,
    output logic                            flushExecute
);

    logic [cpuPkg::regAddrWidth-1:0] exDest;
    logic                            loadUse;

    // memory stage is younger, so it wins
    function automatic cpuPkg::fwdSel_t pickSource(
        input logic [cpuPkg::regAddrWidth-1:0] src,
        input logic [cpuPkg::regAddrWidth-1:0] memDest,
        input logic                            memWrites,
        input logic [cpuPkg::regAddrWidth-1:0] wbDest,
        input logic                            wbWrites
    );
        if (src == '0) begin
            return cpuPkg::fromReg;
        end
        if (memWrites && memDest == src) begin
            return cpuPkg::fromMem;
        end
        if (wbWrites && wbDest == src) begin
            return cpuPkg::fromWb;
        end
        return cpuPkg::fromReg;
    endfunction

    assign fwdA = pickSource(ex.rs, mem.destReg, mem.ctrl.regWrite, wb.destReg, wb.regWrite);
    assign fwdB = pickSource(ex.rt, mem.destReg, mem.ctrl.regWrite, wb.destReg, wb.regWrite);

    assign exDest  = ex.ctrl.destIsRt ? ex.rt : ex.rd;
    assign loadUse = ex.ctrl.memRead && exDest != '0
                     && (exDest == decRs || exDest == decRt);

    assign stallFront   = loadUse && !branchTaken;   // branch kills the consumer anyway
    assign flushDecode  = branchTaken || (isJump && !stallFront);
    assign flushExecute = branchTaken || loadUse;    // bubble into execute

endmodule

/* src/regFile.sv */
module regFile (
    input  logic                            clk,
    input  logic [cpuPkg::regAddrWidth-1:0] readAddrA,
    input  logic [cpuPkg::regAddrWidth-1:0] readAddrB,
    output logic [cpuPkg::dataWidth-1:0]    readDataA,
    output logic [cpuPkg::dataWidth-1:0]    readDataB,
    input  logic                            writeEn,
    input  logic [cpuPkg::regAddrWidth-1:0] writeAddr,
    input  logic [cpuPkg::dataWidth-1:0]    writeData
);

    logic [cpuPkg::dataWidth-1:0] regs [1:31];

    // r0 hardwired, same-cycle write bypasses the array
    function automatic logic [cpuPkg::dataWidth-1:0] readPort(
        input logic [cpuPkg::regAddrWidth-1:0] addr
    );
        if (addr == '0) begin
            return '0;
        end
        if (writeEn && writeAddr == addr) begin
            return writeData;
        end
        return regs[addr];
    endfunction

    assign readDataA = readPort(readAddrA);
    assign readDataB = readPort(readAddrB);

    always_ff @(posedge clk) begin
        if (writeEn && writeAddr != '0) begin
            regs[writeAddr] <= writeData;
        end
    end

endmodule

/* src/decodeUnit.sv */
module decodeUnit (
    input  logic [cpuPkg::dataWidth-1:0] instr,
    input  logic [cpuPkg::dataWidth-1:0] pc,
    output cpuPkg::ctrl_t                ctrl,
    output logic [cpuPkg::dataWidth-1:0] imm,
    output logic                         isJump,
    output logic [cpuPkg::dataWidth-1:0] jumpTarget
);

    cpuPkg::opcode_t              op;
    cpuPkg::funct_t               fn;
    logic                         signExt;
    logic [cpuPkg::dataWidth-1:0] pcPlus4;

    assign op      = cpuPkg::opcode_t'(instr[31:26]);
    assign fn      = cpuPkg::funct_t'(instr[5:0]);
    assign pcPlus4 = pc + cpuPkg::wordBytes;

    assign imm = signExt ? {{16{instr[15]}}, instr[15:0]} : {16'b0, instr[15:0]};
    assign jumpTarget = {pcPlus4[31:28], instr[25:0], 2'b00};

    always_comb begin
        ctrl    = '0;
        signExt = 1'b1;
        isJump  = 1'b0;
        case (op)
            cpuPkg::opSpecial: begin
                ctrl.regWrite = 1'b1;
                case (fn)
                    cpuPkg::fnSll:  ctrl.aluOp = cpuPkg::aluSll;
                    cpuPkg::fnSrl:  ctrl.aluOp = cpuPkg::aluSrl;
                    cpuPkg::fnAddu: ctrl.aluOp = cpuPkg::aluAdd;
                    cpuPkg::fnSubu: ctrl.aluOp = cpuPkg::aluSub;
                    cpuPkg::fnAnd:  ctrl.aluOp = cpuPkg::aluAnd;
                    cpuPkg::fnOr:   ctrl.aluOp = cpuPkg::aluOr;
                    cpuPkg::fnXor:  ctrl.aluOp = cpuPkg::aluXor;
                    cpuPkg::fnSlt:  ctrl.aluOp = cpuPkg::aluSlt;
                    default:        ctrl.regWrite = 1'b0;   // unknown funct
                endcase
            end
            cpuPkg::opAddiu, cpuPkg::opAndi, cpuPkg::opOri, cpuPkg::opLui: begin
                ctrl.useImm   = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.destIsRt = 1'b1;
                case (op)
                    cpuPkg::opAndi: begin
                        ctrl.aluOp = cpuPkg::aluAnd;
                        signExt    = 1'b0;
                    end
                    cpuPkg::opOri: begin
                        ctrl.aluOp = cpuPkg::aluOr;
                        signExt    = 1'b0;
                    end
                    cpuPkg::opLui: ctrl.aluOp = cpuPkg::aluLui;
                    default:       ctrl.aluOp = cpuPkg::aluAdd;
                endcase
            end
            cpuPkg::opLw: begin
                ctrl.useImm   = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.memRead  = 1'b1;
                ctrl.destIsRt = 1'b1;
            end
            cpuPkg::opSw: begin
                ctrl.useImm   = 1'b1;
                ctrl.memWrite = 1'b1;
            end
            cpuPkg::opBeq: ctrl.branchKind = cpuPkg::brEq;
            cpuPkg::opBne: ctrl.branchKind = cpuPkg::brNe;
            cpuPkg::opJ:   isJump = 1'b1;
            default: ;
        endcase

        // canonical nop, also what a flushed F/D holds
        if (instr == '0) begin
            ctrl = '0;
        end
    end

endmodule

/* src/fetchStage.sv */
module fetchStage (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         stall,
    input  logic                         redirect,
    input  logic [cpuPkg::dataWidth-1:0] redirectTarget,
    output logic [cpuPkg::dataWidth-1:0] pc
);

    logic [cpuPkg::dataWidth-1:0] pcNext;

    // a redirect beats a load-use hold
    always_comb begin
        if (redirect) begin
            pcNext = redirectTarget;
        end else if (stall) begin
            pcNext = pc;
        end else begin
            pcNext = pc + cpuPkg::wordBytes;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= cpuPkg::resetVector;
        end else begin
            pc <= pcNext;
        end
    end

endmodule

/* src/cpuPkg.sv */
package cpuPkg;

    localparam int dataWidth    = 32;
    localparam int regAddrWidth = 5;
    localparam int shamtWidth   = 5;

    localparam logic [dataWidth-1:0] resetVector = 32'h0000_0000;
    localparam logic [dataWidth-1:0] wordBytes   = 32'd4;   // pc step

    // primary opcode field, instr[31:26]
    typedef enum logic [5:0] {
        opSpecial = 6'h00,
        opJ       = 6'h02,
        opBeq     = 6'h04,
        opBne     = 6'h05,
        opAddiu   = 6'h09,
        opAndi    = 6'h0c,
        opOri     = 6'h0d,
        opLui     = 6'h0f,
        opLw      = 6'h23,
        opSw      = 6'h2b
    } opcode_t;

    // special function field, instr[5:0]
    typedef enum logic [5:0] {
        fnSll  = 6'h00,
        fnSrl  = 6'h02,
        fnAddu = 6'h21,
        fnSubu = 6'h23,
        fnAnd  = 6'h24,
        fnOr   = 6'h25,
        fnXor  = 6'h26,
        fnSlt  = 6'h2a
    } funct_t;

    typedef enum logic [3:0] {
        aluAdd, aluSub, aluAnd, aluOr, aluXor, aluSlt, aluSll, aluSrl, aluLui
    } aluOp_t;

    typedef enum logic [1:0] {
        fromReg, fromMem, fromWb
    } fwdSel_t;

    typedef enum logic [1:0] {
        brNone, brEq, brNe
    } branchKind_t;

    // all zero is a bubble
    typedef struct packed {
        aluOp_t      aluOp;
        logic        useImm;
        logic        regWrite;
        logic        memRead;
        logic        memWrite;
        branchKind_t branchKind;
        logic        destIsRt;   // rt is the target, not rd
    } ctrl_t;

    typedef struct packed {
        logic [dataWidth-1:0]    pc;
        ctrl_t                   ctrl;
        logic [regAddrWidth-1:0] rs;
        logic [regAddrWidth-1:0] rt;
        logic [regAddrWidth-1:0] rd;
        logic [shamtWidth-1:0]   shamt;
        logic [dataWidth-1:0]    rsValue;
        logic [dataWidth-1:0]    rtValue;
        logic [dataWidth-1:0]    imm;
    } idEx_t;

    typedef struct packed {
        logic [dataWidth-1:0]    pc;
        ctrl_t                   ctrl;
        logic [regAddrWidth-1:0] destReg;
        logic [dataWidth-1:0]    aluResult;
        logic [dataWidth-1:0]    storeData;
    } exMem_t;

    typedef struct packed {
        logic [dataWidth-1:0]    pc;
        logic                    regWrite;
        logic [regAddrWidth-1:0] destReg;
        logic [dataWidth-1:0]    result;
    } memWb_t;

    typedef struct packed {
        logic                 en;
        logic                 wen;
        logic [dataWidth-1:0] addr;
        logic [dataWidth-1:0] wdata;
    } memReq_t;

    typedef struct packed {
        logic [dataWidth-1:0]    pc;
        logic                    wen;
        logic [regAddrWidth-1:0] wnum;
        logic [dataWidth-1:0]    wdata;
    } wbInfo_t;

endpackage
